/* duc_defines.svh */
/*
 * Settings register offsets and fixed filter constants for the
 * up-conversion chain
 */
`ifndef DUC_DEFINES_SVH
`define DUC_DEFINES_SVH

// Register offsets from BASE
`define DUC_SR_PHASE_INC 8'd0   // NCO phase increment
`define DUC_SR_SCALE     8'd1   // I scale [31:16], Q scale [15:0]
`define DUC_SR_RATE      8'd2   // Bit 9 hb enable, bits 7:0 CIC rate

// CIC interpolator
`define DUC_CIC_ORDER    4
`define DUC_CIC_MAX_LOG2 7      // Rates up to 128

// CORDIC shift-add stages after the quadrant step
`define DUC_CORDIC_STAGES 20

// Halfband accumulator, holds 9 * (a + b) - (c + d) for 18-bit taps
`define DUC_HB_ACC_W 24

`endif

/* duc_pkg.sv */
/*
 * Width types shared by the up-conversion chain
 */
package duc_pkg;

   // Settings bus
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Baseband component or scale factor
   typedef logic signed [15:0] iq_t;

   // Filter datapath, input widened by two LSBs
   typedef logic signed [17:0] sample_t;

   typedef logic [31:0] phase_t;    // NCO accumulator and increment
   typedef logic [23:0] angle_t;    // Top of the phase, full turn is 2^24

   typedef logic signed [23:0] cordic_t;

   typedef logic [7:0] rate_t;      // CIC interpolation rate

   // Word sent to the transmit frontend
   typedef logic signed [23:0] fe_t;

endpackage

/* setting_reg.sv */
/*
 * Host-writable settings register with change flag
 */
`timescale 1ns/1ps

module setting_reg #(
   parameter duc_pkg::set_addr_t ADDR      = 8'd0,
   parameter int                 WIDTH     = 32,
   parameter logic [WIDTH-1:0]   RESET_VAL = '0
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               strobe_i,
   input  duc_pkg::set_addr_t addr_i,
   input  duc_pkg::set_data_t data_i,
   output logic [WIDTH-1:0]   value_o,
   output logic               changed_o
);

   always_ff @(posedge clk) begin
      if (rst) begin
         value_o   <= RESET_VAL;
         changed_o <= 1'b0;
      end else begin
         changed_o <= 1'b0;   // Single cycle pulse
         if (strobe_i && (addr_i == ADDR)) begin
            value_o   <= data_i[WIDTH-1:0];
            changed_o <= 1'b1;
         end
      end
   end

endmodule

/* rate_strober.sv */
/*
 * Strobe divider, passes one fast strobe out of every rate_i
 */
`timescale 1ns/1ps

module rate_strober #(
   parameter int WIDTH = 8
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             enable_i,
   input  logic [WIDTH-1:0] rate_i,
   input  logic             strobe_fast_i,
   output logic             strobe_slow_o
);

   logic [WIDTH-1:0] count;
   logic             at_zero;

   assign at_zero = (count == '0);

   // Counter sits at zero while idle, so the first fast strobe goes out
   always_ff @(posedge clk) begin
      if (rst || !enable_i) begin
         count <= '0;
      end else if (strobe_fast_i) begin
         if (at_zero) begin
            count <= rate_i - 1'b1;   // Reload, rate of 1 stays at zero
         end else begin
            count <= count - 1'b1;
         end
      end
   end

   assign strobe_slow_o = enable_i && at_zero && strobe_fast_i;

endmodule

/* hb_interp.sv */
/*
 * Halfband x2 interpolator, 7 taps with coefficients -1/16 0 9/16 1 9/16 0 -1/16,
 * and a registered bypass path
 */
`timescale 1ns/1ps
`include "duc_defines.svh"

module hb_interp (
   input  logic             clk,
   input  logic             rst,
   input  logic             bypass_i,
   input  logic             stb_in_i,
   input  duc_pkg::sample_t data_i,
   input  logic             stb_out_i,
   output duc_pkg::sample_t data_o
);

   localparam int ACC_W = `DUC_HB_ACC_W;
   localparam int SW    = $bits(duc_pkg::sample_t);

   // Output clip limits in accumulator width
   localparam logic signed [ACC_W-1:0] SAT_HI = 2 ** (SW - 1) - 1;
   localparam logic signed [ACC_W-1:0] SAT_LO = -(2 ** (SW - 1));

   duc_pkg::sample_t        taps [4];   // taps[0] is the newest sample
   logic signed [ACC_W-1:0] inner;
   logic signed [ACC_W-1:0] outer;
   logic signed [ACC_W-1:0] acc;
   logic signed [ACC_W-1:0] rounded;
   duc_pkg::sample_t        interp;

   // Odd phase, midway between taps[2] and taps[1]
   always_comb begin
      inner   = ACC_W'(taps[1]) + ACC_W'(taps[2]);
      outer   = ACC_W'(taps[0]) + ACC_W'(taps[3]);
      acc     = (inner <<< 3) + inner - outer;      // 9 * inner - outer
      rounded = (acc + ACC_W'(8)) >>> 4;            // Divide by 16, round half up

      // Overshoot on full-scale steps can exceed the sample range
      if (rounded > SAT_HI) begin
         interp = SAT_HI[SW-1:0];
      end else if (rounded < SAT_LO) begin
         interp = SAT_LO[SW-1:0];
      end else begin
         interp = rounded[SW-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 4; i++) begin
            taps[i] <= '0;
         end
         data_o <= '0;
      end else if (bypass_i) begin
         if (stb_in_i) begin
            data_o <= data_i;
         end
      end else begin
         if (stb_in_i) begin
            taps[0] <= data_i;
            taps[1] <= taps[0];
            taps[2] <= taps[1];
            taps[3] <= taps[2];
         end
         if (stb_out_i) begin
            // Input strobe marks the even phase, the centre tap passes
            if (stb_in_i) begin
               data_o <= taps[1];   // Becomes taps[2] this edge
            end else begin
               data_o <= interp;
            end
         end
      end
   end

endmodule

/* cic_interp.sv */
/*
 * CIC interpolator, comb stages on the input strobe, integrators every cycle,
 * output normalised by 3 * log2(rate)
 */
`timescale 1ns/1ps
`include "duc_defines.svh"

module cic_interp (
   input  logic             clk,
   input  logic             rst,
   input  logic             enable_i,
   input  duc_pkg::rate_t   rate_i,
   input  logic             stb_in_i,
   input  duc_pkg::sample_t data_i,
   output duc_pkg::sample_t data_o
);

   localparam int N  = `DUC_CIC_ORDER;
   localparam int IW = $bits(duc_pkg::sample_t);
   localparam int W  = IW + N * `DUC_CIC_MAX_LOG2;   // Bit growth for the top rate

   logic [N:0]          stb_vec;    // stb_vec[k] is stb_in_i delayed k cycles
   logic [N-1:0]        stb_dly;
   logic signed [W-1:0] comb_in  [N];
   logic signed [W-1:0] comb     [N];
   logic signed [W-1:0] comb_dly [N];
   logic signed [W-1:0] up;
   logic signed [W-1:0] integ    [N];
   logic signed [W-1:0] scaled;
   logic [4:0]          shift;

   // Ceiling log2, exact for power-of-two rates
   function automatic logic [3:0] clog2_rate(input duc_pkg::rate_t r);
      logic [3:0]     n;
      duc_pkg::rate_t rm1;
      n   = '0;
      rm1 = r - 1'b1;
      for (int i = 0; i < 8; i++) begin
         if (|(rm1 >> i)) begin
            n = 4'(i + 1);
         end
      end
      return n;
   endfunction

   // Gain of the interpolating CIC is R^(N-1)
   assign shift  = 5'(3 * clog2_rate(rate_i));
   assign scaled = integ[N-1] >>> shift;

   always_comb begin
      stb_vec    = {stb_dly, stb_in_i};
      comb_in[0] = W'(data_i);
      for (int k = 1; k < N; k++) begin
         comb_in[k] = comb[k-1];
      end
   end

   always_ff @(posedge clk) begin
      if (rst || !enable_i) begin
         stb_dly <= '0;
         up      <= '0;
         data_o  <= '0;
         for (int k = 0; k < N; k++) begin
            comb[k]     <= '0;
            comb_dly[k] <= '0;
            integ[k]    <= '0;
         end
      end else begin
         stb_dly <= stb_vec[N-1:0];

         // Each comb fires one cycle after the one before it
         for (int k = 0; k < N; k++) begin
            if (stb_vec[k]) begin
               comb[k]     <= comb_in[k] - comb_dly[k];
               comb_dly[k] <= comb_in[k];
            end
         end

         up <= stb_vec[N] ? comb[N-1] : '0;   // Zero stuffing

         integ[0] <= integ[0] + up;
         for (int k = 1; k < N; k++) begin
            integ[k] <= integ[k] + integ[k-1];
         end

         data_o <= scaled[IW-1:0];
      end
   end

endmodule

/* cordic_rotator.sv */
/*
 * Pipelined CORDIC vector rotator with quadrant pre-rotation,
 * 24-bit angle where a full turn is 2^24
 */
`timescale 1ns/1ps
`include "duc_defines.svh"

module cordic_rotator (
   input  logic             clk,
   input  logic             rst,
   input  logic             enable_i,
   input  duc_pkg::cordic_t x_i,
   input  duc_pkg::cordic_t y_i,
   input  duc_pkg::angle_t  angle_i,
   output duc_pkg::cordic_t x_o,
   output duc_pkg::cordic_t y_o
);

   localparam int S  = `DUC_CORDIC_STAGES;
   localparam int DW = $bits(duc_pkg::cordic_t);
   localparam int CW = DW + 2;                  // Headroom for the 1.6468 gain
   localparam int ZW = $bits(duc_pkg::angle_t);
   localparam logic [ZW-1:0] QUARTER = ZW'(1) << (ZW - 2);   // 90 degrees

   logic signed [CW-1:0] x [S+1];
   logic signed [CW-1:0] y [S+1];
   logic signed [ZW-1:0] z [S];
   logic signed [CW-1:0] x_ext;
   logic signed [CW-1:0] y_ext;

   // atan(2^-i) scaled to 2^24 per turn
   function automatic logic [ZW-1:0] atan_lut(input int i);
      case (i)
         0:       return 24'd2097152;
         1:       return 24'd1238021;
         2:       return 24'd654136;
         3:       return 24'd332050;
         4:       return 24'd166669;
         5:       return 24'd83416;
         6:       return 24'd41718;
         7:       return 24'd20860;
         8:       return 24'd10430;
         9:       return 24'd5215;
         10:      return 24'd2608;
         11:      return 24'd1304;
         12:      return 24'd652;
         13:      return 24'd326;
         14:      return 24'd163;
         15:      return 24'd81;
         16:      return 24'd41;
         17:      return 24'd20;
         18:      return 24'd10;
         19:      return 24'd5;
         default: return '0;
      endcase
   endfunction

   // Clip the guard bits back to the output word
   function automatic duc_pkg::cordic_t clip(input logic signed [CW-1:0] v);
      if ((&v[CW-1:DW-1]) || !(|v[CW-1:DW-1])) begin
         return v[DW-1:0];
      end
      return {v[CW-1], {(DW - 1){~v[CW-1]}}};
   endfunction

   assign x_ext = CW'(x_i);
   assign y_ext = CW'(y_i);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i <= S; i++) begin
            x[i] <= '0;
            y[i] <= '0;
         end
         for (int i = 0; i < S; i++) begin
            z[i] <= '0;
         end
      end else if (enable_i) begin
         // Bring the residual angle into -90..+90 degrees
         case (angle_i[ZW-1 -: 2])
            2'b01: begin
               x[0] <= -y_ext;
               y[0] <= x_ext;
               z[0] <= angle_i - QUARTER;
            end
            2'b10: begin
               x[0] <= y_ext;
               y[0] <= -x_ext;
               z[0] <= angle_i + QUARTER;
            end
            default: begin
               x[0] <= x_ext;
               y[0] <= y_ext;
               z[0] <= angle_i;
            end
         endcase

         for (int i = 0; i < S; i++) begin
            if (z[i][ZW-1]) begin   // Negative residual, turn clockwise
               x[i+1] <= x[i] + (y[i] >>> i);
               y[i+1] <= y[i] - (x[i] >>> i);
            end else begin
               x[i+1] <= x[i] - (y[i] >>> i);
               y[i+1] <= y[i] + (x[i] >>> i);
            end
         end

         // Last stage needs no residual
         for (int i = 0; i < S - 1; i++) begin
            if (z[i][ZW-1]) begin
               z[i+1] <= z[i] + atan_lut(i);
            end else begin
               z[i+1] <= z[i] - atan_lut(i);
            end
         end
      end
   end

   assign x_o = clip(x[S]);
   assign y_o = clip(y[S]);

endmodule

/* duc_chain.sv */
/*
 * Digital up-conversion top level: settings registers, strobe dividers, NCO,
 * halfband and CIC interpolators, CORDIC rotator and output scaling
 */
`timescale 1ns/1ps
`include "duc_defines.svh"

module duc_chain #(
   parameter duc_pkg::set_addr_t BASE = 8'd0
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               set_stb_i,
   input  duc_pkg::set_addr_t set_addr_i,
   input  duc_pkg::set_data_t set_data_i,
   input  duc_pkg::set_data_t sample_i,
   input  logic               run_i,
   output logic               strobe_o,
   output duc_pkg::fe_t       tx_fe_i_o,
   output duc_pkg::fe_t       tx_fe_q_o
);

   localparam int SCALE_FRAC = 15;   // Scale words are Q15
   localparam int PAD_W = $bits(duc_pkg::cordic_t) - $bits(duc_pkg::sample_t);

   duc_pkg::phase_t    phase_inc;
   duc_pkg::phase_t    phase;
   duc_pkg::set_data_t scale_word;
   duc_pkg::iq_t       scale_i;
   duc_pkg::iq_t       scale_q;
   logic [9:0]         rate_ctrl;
   logic               hb_en;
   duc_pkg::rate_t     cic_rate;
   logic               rate_change;
   logic               strober_en;

   logic cic_stb_pre;
   logic hb_stb_pre;
   logic cic_stb;
   logic hb_stb;

   duc_pkg::sample_t     bb_i, bb_q;
   duc_pkg::sample_t     hb_i, hb_q;
   duc_pkg::sample_t     cic_i, cic_q;
   duc_pkg::cordic_t     rot_i, rot_q;
   logic signed [39:0]   prod_i, prod_q;

   // Settings
   setting_reg #(.ADDR(BASE + `DUC_SR_PHASE_INC), .WIDTH(32)) i_sr_phase (
      .clk       (clk),
      .rst       (rst),
      .strobe_i  (set_stb_i),
      .addr_i    (set_addr_i),
      .data_i    (set_data_i),
      .value_o   (phase_inc),
      .changed_o ()
   );

   setting_reg #(.ADDR(BASE + `DUC_SR_SCALE), .WIDTH(32)) i_sr_scale (
      .clk       (clk),
      .rst       (rst),
      .strobe_i  (set_stb_i),
      .addr_i    (set_addr_i),
      .data_i    (set_data_i),
      .value_o   (scale_word),
      .changed_o ()
   );

   setting_reg #(.ADDR(BASE + `DUC_SR_RATE), .WIDTH(10), .RESET_VAL(10'd1)) i_sr_rate (
      .clk       (clk),
      .rst       (rst),
      .strobe_i  (set_stb_i),
      .addr_i    (set_addr_i),
      .data_i    (set_data_i),
      .value_o   (rate_ctrl),
      .changed_o (rate_change)
   );

   assign scale_i  = scale_word[31:16];
   assign scale_q  = scale_word[15:0];
   assign hb_en    = rate_ctrl[9];
   assign cic_rate = rate_ctrl[7:0];

   // Strobe generation, restarted on every rate write
   assign strober_en = run_i && !rate_change;

   rate_strober #(.WIDTH(8)) i_cic_strober (
      .clk           (clk),
      .rst           (rst),
      .enable_i      (strober_en),
      .rate_i        (cic_rate),
      .strobe_fast_i (1'b1),
      .strobe_slow_o (cic_stb_pre)
   );

   rate_strober #(.WIDTH(2)) i_hb_strober (
      .clk           (clk),
      .rst           (rst),
      .enable_i      (strober_en),
      .rate_i        (hb_en ? 2'd2 : 2'd1),
      .strobe_fast_i (cic_stb_pre),
      .strobe_slow_o (hb_stb_pre)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         cic_stb <= 1'b0;
         hb_stb  <= 1'b0;
      end else begin
         cic_stb <= cic_stb_pre;   // One register stage for timing
         hb_stb  <= hb_stb_pre;
      end
   end

   assign strobe_o = hb_stb;   // Sample request to the source

   // NCO
   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         phase <= '0;
      end else begin
         phase <= phase + phase_inc;
      end
   end

   // Baseband split and widen
   assign bb_i = {sample_i[31:16], 2'b00};
   assign bb_q = {sample_i[15:0], 2'b00};

   hb_interp i_hb_i (
      .clk       (clk),
      .rst       (rst),
      .bypass_i  (!hb_en),
      .stb_in_i  (hb_stb),
      .data_i    (bb_i),
      .stb_out_i (cic_stb),
      .data_o    (hb_i)
   );

   hb_interp i_hb_q (
      .clk       (clk),
      .rst       (rst),
      .bypass_i  (!hb_en),
      .stb_in_i  (hb_stb),
      .data_i    (bb_q),
      .stb_out_i (cic_stb),
      .data_o    (hb_q)
   );

   cic_interp i_cic_i (
      .clk      (clk),
      .rst      (rst),
      .enable_i (strober_en),
      .rate_i   (cic_rate),
      .stb_in_i (cic_stb),
      .data_i   (hb_i),
      .data_o   (cic_i)
   );

   cic_interp i_cic_q (
      .clk      (clk),
      .rst      (rst),
      .enable_i (strober_en),
      .rate_i   (cic_rate),
      .stb_in_i (cic_stb),
      .data_i   (hb_q),
      .data_o   (cic_q)
   );

   cordic_rotator i_cordic (
      .clk      (clk),
      .rst      (rst),
      .enable_i (run_i),
      .x_i      ({cic_i, {PAD_W{1'b0}}}),
      .y_i      ({cic_q, {PAD_W{1'b0}}}),
      .angle_i  (phase[31 -: $bits(duc_pkg::angle_t)]),
      .x_o      (rot_i),
      .y_o      (rot_q)
   );

   // Output scaling
   always_ff @(posedge clk) begin
      if (rst) begin
         prod_i <= '0;
         prod_q <= '0;
      end else begin
         prod_i <= (rot_i * scale_i) >>> SCALE_FRAC;
         prod_q <= (rot_q * scale_q) >>> SCALE_FRAC;
      end
   end

   assign tx_fe_i_o = prod_i[28:5];
   assign tx_fe_q_o = prod_q[28:5];

endmodule

/* tb_duc_chain.sv */
/*
 * Testbench for the up-conversion chain: settings writes, sample source,
 * strobe spacing, gain, rotation and output bound checks
 */
`timescale 1ns/1ps
`include "duc_defines.svh"

module tb_duc_chain;

   localparam duc_pkg::set_addr_t BASE = 8'd0;
   localparam real CORDIC_GAIN = 1.6468;
   localparam real TOL         = 0.02;
   localparam real SCALE       = 16384.0;   // 0.5 in Q15
   localparam int  S_I         = 8000;
   localparam int  S_Q         = -5000;
   localparam int  STB_LIMIT   = 600;       // Longest spacing is 256 cycles
   localparam int  DRAIN       = 40;        // CIC, CORDIC and multiplier

   logic               clk;
   logic               rst;
   logic               set_stb_i;
   duc_pkg::set_addr_t set_addr_i;
   duc_pkg::set_data_t set_data_i;
   duc_pkg::set_data_t sample_i;
   logic               run_i;
   logic               strobe_o;
   duc_pkg::fe_t       tx_fe_i_o;
   duc_pkg::fe_t       tx_fe_q_o;

   int                 errors       = 0;
   int                 timeouts     = 0;
   int                 tests        = 0;
   int                 tests_failed = 0;
   int                 seed         = 4315;
   int                 max_abs      = 0;
   bit                 src_random   = 1'b0;
   bit                 bound_on     = 1'b0;
   duc_pkg::set_data_t src_const    = '0;

   duc_chain #(.BASE(BASE)) i_dut (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .sample_i   (sample_i),
      .run_i      (run_i),
      .strobe_o   (strobe_o),
      .tx_fe_i_o  (tx_fe_i_o),
      .tx_fe_q_o  (tx_fe_q_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Steady frontend word for a constant component s and Q15 scale k
   function automatic real expected_fe(input real s, input real k);
      return s * 4.0 * CORDIC_GAIN * 64.0 * k / 32768.0 / 32.0;
   endfunction

   function automatic real abs_real(input real v);
      return (v < 0.0) ? -v : v;
   endfunction

   // Sample source, the next word goes out on the edge that ends a request
   always @(posedge clk) begin : source
      logic [31:0]  r;
      duc_pkg::iq_t ri;
      duc_pkg::iq_t rq;
      if (strobe_o) begin
         if (src_random) begin
            r  = $random(seed);
            ri = $signed(r[13:0]);
            rq = $signed(r[29:16]);
            if (abs_real(ri) > max_abs) begin
               max_abs = int'(abs_real(ri));
            end
            if (abs_real(rq) > max_abs) begin
               max_abs = int'(abs_real(rq));
            end
            sample_i <= {ri, rq};
         end else begin
            sample_i <= src_const;
         end
      end
   end

   // Requests stay quiet once run_i has been low for a full cycle
   assert property (@(posedge clk) disable iff (rst) (!run_i && !$past(run_i)) |-> !strobe_o)
      else begin
         $display("Error: strobe_o = 0x%0h while run_i is low, expected 0x0", strobe_o);
         errors++;
      end

   // Halfband overshoot (1.25) times the I/Q vector length (sqrt 2) stays under 2
   always @(negedge clk) begin : bound_check
      real bound;
      if (bound_on) begin
         bound = 2.0 * expected_fe(max_abs, SCALE) * (1.0 + TOL) + 4.0;
         assert (abs_real(tx_fe_i_o) <= bound && abs_real(tx_fe_q_o) <= bound) else begin
            $display("Error: tx_fe_i_o = 0x%06h tx_fe_q_o = 0x%06h, bound 0x%06h",
                     tx_fe_i_o, tx_fe_q_o, longint'(bound));
            errors++;
         end
      end
   end

   task automatic write_setting(input duc_pkg::set_addr_t addr,
                                input duc_pkg::set_data_t data);
      @(posedge clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(posedge clk);
      set_stb_i  <= 1'b0;
   endtask

   task automatic wait_strobe(output int cycles);
      bit found;
      found  = 1'b0;
      cycles = 0;
      while (!found && cycles < STB_LIMIT) begin
         @(negedge clk);
         cycles++;
         found = strobe_o;
      end
      if (!found) begin
         $display("Timeout: no strobe_o pulse within %0d cycles", STB_LIMIT);
         timeouts++;
         errors++;
      end
   endtask

   task automatic settle(input int strobes);
      int gap;
      for (int n = 0; n < strobes; n++) begin
         wait_strobe(gap);
      end
      repeat (DRAIN) @(negedge clk);
   endtask

   task automatic check_spacing(input int expected);
      int gap;
      settle(3);   // Skip the restart after a rate write
      for (int n = 0; n < 4; n++) begin
         wait_strobe(gap);
         if (n > 0) begin
            assert (gap == expected) else begin
               $display("Error: strobe_o spacing = 0x%0h, expected 0x%0h", gap, expected);
               errors++;
            end
         end
      end
   endtask

   task automatic check_near(input string name, input longint actual,
                             input real expected, input real rel);
      real tol;
      tol = rel * abs_real(expected) + 4.0;
      assert (abs_real(actual - expected) <= tol) else begin
         $display("Error: %s = 0x%0h, expected 0x%0h", name, actual, longint'(expected));
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("Test %0d %s: ok", tests, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d errors", tests, name, errors - errs_before);
      end
   endtask

   initial begin
      int           start;
      longint       ti [5];
      longint       tq [5];
      duc_pkg::fe_t ref_i;
      duc_pkg::fe_t ref_q;
      real          mag;

      rst        = 1'b1;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      sample_i   = '0;
      run_i      = 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      start = errors;
      repeat (20) begin
         @(negedge clk);
         assert (!strobe_o && tx_fe_i_o == 0 && tx_fe_q_o == 0) else begin
            $display("Error: strobe_o = 0x%0h tx_fe_i_o = 0x%06h tx_fe_q_o = 0x%06h, expected 0",
                     strobe_o, tx_fe_i_o, tx_fe_q_o);
            errors++;
         end
      end
      finish_test("idle after reset", start);

      start = errors;
      write_setting(BASE + `DUC_SR_RATE, 32'd8);
      @(posedge clk);
      run_i <= 1'b1;
      check_spacing(8);
      write_setting(BASE + `DUC_SR_RATE, 32'h0000_0208);   // Halfband on, rate 8
      check_spacing(16);
      finish_test("strobe spacing", start);

      start = errors;
      write_setting(BASE + `DUC_SR_SCALE, 32'h4000_4000);
      src_const = {16'(S_I), 16'(S_Q)};
      settle(12);
      repeat (8) begin
         @(negedge clk);
         check_near("tx_fe_i_o", tx_fe_i_o, expected_fe(S_I, SCALE), TOL);
         check_near("tx_fe_q_o", tx_fe_q_o, expected_fe(S_Q, SCALE), TOL);
      end
      finish_test("gain at zero phase", start);

      start = errors;
      write_setting(BASE + `DUC_SR_PHASE_INC, 32'h4000_0000);   // Quarter turn per cycle
      src_const = {16'(S_I), 16'd0};
      settle(12);
      mag = expected_fe(S_I, SCALE);
      for (int n = 0; n < 5; n++) begin
         @(negedge clk);
         ti[n] = tx_fe_i_o;
         tq[n] = tx_fe_q_o;
         check_near("tx_fe_i_o^2 + tx_fe_q_o^2", ti[n] * ti[n] + tq[n] * tq[n],
                    mag * mag, 2.0 * TOL);
      end
      // Counter-clockwise quarter turn maps (I, Q) to (-Q, I)
      for (int n = 0; n < 4; n++) begin
         check_near("tx_fe_i_o", ti[n+1], -tq[n], TOL);
         check_near("tx_fe_q_o", tq[n+1], ti[n], TOL);
      end
      finish_test("quarter turn rotation", start);

      start = errors;
      write_setting(BASE + `DUC_SR_PHASE_INC, 32'd0);
      src_const = {16'(S_I), 16'(S_Q)};
      settle(12);
      @(negedge clk);
      ref_i = tx_fe_i_o;
      ref_q = tx_fe_q_o;
      write_setting(BASE + 8'd5, 32'hFFFF_FFFF);   // No register here
      repeat (DRAIN) begin
         @(negedge clk);
         assert (tx_fe_i_o == ref_i && tx_fe_q_o == ref_q) else begin
            $display("Error: tx_fe_i_o = 0x%06h tx_fe_q_o = 0x%06h, expected 0x%06h 0x%06h",
                     tx_fe_i_o, tx_fe_q_o, ref_i, ref_q);
            errors++;
         end
      end
      write_setting(BASE + `DUC_SR_SCALE, 32'd0);
      repeat (4) @(negedge clk);
      repeat (8) begin
         @(negedge clk);
         assert (tx_fe_i_o == 0 && tx_fe_q_o == 0) else begin
            $display("Error: tx_fe_i_o = 0x%06h tx_fe_q_o = 0x%06h, expected 0x000000",
                     tx_fe_i_o, tx_fe_q_o);
            errors++;
         end
      end
      finish_test("unmapped write and zero scale", start);

      start = errors;
      write_setting(BASE + `DUC_SR_SCALE, 32'h4000_4000);
      write_setting(BASE + `DUC_SR_PHASE_INC, 32'h0123_4567);
      max_abs    = (S_I > -S_Q) ? S_I : -S_Q;   // Constant samples still in flight
      src_random = 1'b1;
      bound_on   = 1'b1;
      settle(100);
      bound_on = 1'b0;
      assert (timeouts == 0) else begin
         $display("Run ended with %0d strobe timeouts", timeouts);
         errors++;
      end
      finish_test("random samples within bound", start);

      $display("Tests run: %0d, failed: %0d, check errors: %0d, timeouts: %0d",
               tests, tests_failed, errors, timeouts);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+.
duc_pkg.sv
setting_reg.sv
rate_strober.sv
hb_interp.sv
cic_interp.sv
cordic_rotator.sv
duc_chain.sv
tb_duc_chain.sv
